// File: Makefile
# Verilator flow for the AES whitening accelerator

VERILATOR ?= verilator
TOP       ?= tb_aes_hwpe
RTL_TOP   ?= aes_hwpe_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= >>> PASS
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The verdict comes from the log, not from the exit code of the binary
sim: build
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx '$(PASS_MSG)' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: aes_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module aes_fsm (
  input  wire logic           clk,
  input  wire logic           reset_n,
  input  wire logic           clear_i,
  input  wire logic           start_i,
  input  aes_pkg::addr_t      pt_base_i,
  input  aes_pkg::addr_t      ct_base_i,
  streamer_ctrl_if.ctrl       src_ctrl,
  streamer_ctrl_if.ctrl       snk_ctrl,
  output logic                busy_o,
  output logic                done_o
);

  aes_pkg::aes_state_t state_q, state_d;
  aes_pkg::addr_t      pt_base_q, ct_base_q;
  logic                both_ready;

  assign both_ready = src_ctrl.ready_start && snk_ctrl.ready_start;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= aes_pkg::AES_IDLE;
    end else if (clear_i) begin
      state_q <= aes_pkg::AES_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Bases are captured with the start pulse
  always_ff @(posedge clk) begin
    if (state_q == aes_pkg::AES_IDLE && start_i) begin
      pt_base_q <= pt_base_i;
      ct_base_q <= ct_base_i;
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      aes_pkg::AES_IDLE:     if (start_i) state_d = aes_pkg::AES_STARTING;
      aes_pkg::AES_STARTING: if (both_ready) state_d = aes_pkg::AES_WORKING;
      // The sink sees the last write, so it decides when the job ends
      aes_pkg::AES_WORKING:  if (snk_ctrl.finished) state_d = aes_pkg::AES_FINISHED;
      aes_pkg::AES_FINISHED: state_d = aes_pkg::AES_IDLE;
      default:               state_d = aes_pkg::AES_IDLE;
    endcase
  end

  // Both streamers take the job in the same cycle
  assign src_ctrl.req_start = (state_q == aes_pkg::AES_STARTING) && both_ready;
  assign snk_ctrl.req_start = (state_q == aes_pkg::AES_STARTING) && both_ready;
  assign src_ctrl.base_addr = pt_base_q;
  assign snk_ctrl.base_addr = ct_base_q;

  assign busy_o = (state_q != aes_pkg::AES_IDLE);
  assign done_o = (state_q == aes_pkg::AES_FINISHED);

  a_done_single: assert property (@(posedge clk) disable iff (!reset_n)
    done_o |=> !done_o)
    else $error("done_o held for two cycles");

  a_finish_in_working: assert property (@(posedge clk) disable iff (!reset_n)
    snk_ctrl.finished |-> state_q == aes_pkg::AES_WORKING)
    else $error("Sink finished in state %s", state_q.name());

  a_src_finish_in_working: assert property (@(posedge clk) disable iff (!reset_n)
    src_ctrl.finished |-> state_q == aes_pkg::AES_WORKING)
    else $error("Source finished in state %s", state_q.name());

endmodule

`default_nettype wire

// File: aes_hwpe_top.sv
`timescale 1ns/1ps
`default_nettype none

module aes_hwpe_top (
  input  wire logic       clk,
  input  wire logic       reset_n,
  input  wire logic       clear_i,
  input  wire logic       start_i,
  input  aes_pkg::addr_t  pt_base_i,
  input  aes_pkg::addr_t  ct_base_i,
  input  aes_pkg::key_t   key_i,
  output logic            busy_o,
  output logic            done_o,
  // Memory read port
  output logic            rd_req_o,
  output aes_pkg::addr_t  rd_addr_o,
  input  aes_pkg::word_t  rd_data_i,
  // Memory write port
  output logic            wr_req_o,
  output aes_pkg::addr_t  wr_addr_o,
  output aes_pkg::word_t  wr_data_o,
  input  wire logic       wr_ready_i
);

  streamer_ctrl_if src_ctrl ();
  streamer_ctrl_if snk_ctrl ();
  word_fifo_if     fifo_bus ();

  aes_fsm i_fsm (
    .clk       (clk),
    .reset_n   (reset_n),
    .clear_i   (clear_i),
    .start_i   (start_i),
    .pt_base_i (pt_base_i),
    .ct_base_i (ct_base_i),
    .src_ctrl  (src_ctrl.ctrl),
    .snk_ctrl  (snk_ctrl.ctrl),
    .busy_o    (busy_o),
    .done_o    (done_o)
  );

  plaintext_source i_source (
    .clk       (clk),
    .reset_n   (reset_n),
    .clear_i   (clear_i),
    .ctrl      (src_ctrl.streamer),
    .fifo      (fifo_bus.producer),
    .rd_req_o  (rd_req_o),
    .rd_addr_o (rd_addr_o),
    .rd_data_i (rd_data_i)
  );

  word_fifo i_fifo (
    .clk     (clk),
    .reset_n (reset_n),
    .clear_i (clear_i),
    .fifo    (fifo_bus.buffer)
  );

  ciphertext_sink i_sink (
    .clk        (clk),
    .reset_n    (reset_n),
    .clear_i    (clear_i),
    .ctrl       (snk_ctrl.streamer),
    .fifo       (fifo_bus.consumer),
    .key_i      (key_i),
    .wr_req_o   (wr_req_o),
    .wr_ready_i (wr_ready_i),
    .wr_addr_o  (wr_addr_o),
    .wr_data_o  (wr_data_o)
  );

endmodule

`default_nettype wire

// File: aes_pkg.sv
`default_nettype none

package aes_pkg;

  // Job geometry
  localparam int unsigned WORD_BYTES  = 4;
  localparam int unsigned LINE_LENGTH = 8;

  // Decoupling buffer between read and write side
  localparam int unsigned FIFO_DEPTH  = 4;

  // Data and address vectors
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;

  // Whitening key with word 0 in bits 127:96
  typedef logic [127:0] key_t;

  // Word counter within one job
  typedef logic [$clog2(LINE_LENGTH)-1:0] word_idx_t;

  // FIFO pointers and occupancy
  typedef logic [$clog2(FIFO_DEPTH)-1:0] fifo_ptr_t;
  typedef logic [$clog2(FIFO_DEPTH):0]   fifo_cnt_t;

  // Job controller states
  typedef enum logic [1:0] {
    AES_IDLE,
    AES_STARTING,
    AES_WORKING,
    AES_FINISHED
  } aes_state_t;

endpackage

`default_nettype wire

// File: ciphertext_sink.sv
`timescale 1ns/1ps
`default_nettype none

module ciphertext_sink (
  input  wire logic          clk,
  input  wire logic          reset_n,
  input  wire logic          clear_i,
  streamer_ctrl_if.streamer  ctrl,
  word_fifo_if.consumer      fifo,
  input  aes_pkg::key_t      key_i,
  output logic               wr_req_o,
  input  wire logic          wr_ready_i,
  output aes_pkg::addr_t     wr_addr_o,
  output aes_pkg::word_t     wr_data_o
);

  logic               active_q;
  logic               out_valid_q;
  aes_pkg::word_idx_t pop_idx_q, wr_cnt_q;
  aes_pkg::key_t      key_q;
  aes_pkg::addr_t     addr_q;
  aes_pkg::word_t     data_q;
  logic [1:0]         key_sel;
  logic               accept, wr_done, last_wr;

  assign accept  = ctrl.req_start && !active_q;
  assign wr_done = out_valid_q && wr_ready_i;
  assign last_wr = wr_done && (wr_cnt_q == aes_pkg::word_idx_t'(aes_pkg::LINE_LENGTH - 1));

  // Refill the output register when it is empty or leaving this cycle
  assign fifo.pop = active_q && !fifo.empty && (!out_valid_q || wr_done);

  // Key word 0 is the top slice, so invert the index
  assign key_sel = ~pop_idx_q[1:0];

  assign ctrl.ready_start = !active_q;
  assign ctrl.finished    = last_wr;

  assign wr_req_o  = out_valid_q;
  assign wr_addr_o = addr_q;
  assign wr_data_o = data_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      active_q    <= 1'b0;
      out_valid_q <= 1'b0;
      pop_idx_q   <= '0;
      wr_cnt_q    <= '0;
    end else if (clear_i) begin
      active_q    <= 1'b0;
      out_valid_q <= 1'b0;
      pop_idx_q   <= '0;
      wr_cnt_q    <= '0;
    end else begin
      if (accept) begin
        active_q  <= 1'b1;
        pop_idx_q <= '0;
        wr_cnt_q  <= '0;
      end
      if (fifo.pop) begin
        out_valid_q <= 1'b1;
        pop_idx_q   <= pop_idx_q + 1'b1;
      end else if (wr_done) begin
        out_valid_q <= 1'b0;
      end
      if (wr_done) wr_cnt_q <= wr_cnt_q + 1'b1;
      if (last_wr) active_q <= 1'b0;
    end
  end

  // Key, address and output data registers
  always_ff @(posedge clk) begin
    if (accept) begin
      key_q  <= key_i;
      addr_q <= ctrl.base_addr;
    end else if (wr_done) begin
      addr_q <= addr_q + aes_pkg::addr_t'(aes_pkg::WORD_BYTES);
    end
    if (fifo.pop) begin
      data_q <= fifo.pop_data ^ key_q[32 * key_sel +: 32];
    end
  end

  a_hold_on_stall: assert property (@(posedge clk) disable iff (!reset_n || clear_i)
    wr_req_o && !wr_ready_i |=> wr_req_o && $stable(wr_addr_o) && $stable(wr_data_o))
    else $error("Write request changed while stalled");

endmodule

`default_nettype wire

// File: compile.f
aes_pkg.sv
streamer_ctrl_if.sv
word_fifo_if.sv
aes_fsm.sv
plaintext_source.sv
word_fifo.sv
ciphertext_sink.sv
aes_hwpe_top.sv
tb_aes_hwpe.sv

// File: plaintext_source.sv
`timescale 1ns/1ps
`default_nettype none

module plaintext_source (
  input  wire logic          clk,
  input  wire logic          reset_n,
  input  wire logic          clear_i,
  streamer_ctrl_if.streamer  ctrl,
  word_fifo_if.producer      fifo,
  output logic               rd_req_o,
  output aes_pkg::addr_t     rd_addr_o,
  input  aes_pkg::word_t     rd_data_i
);

  logic               active_q;
  logic               pending_q;
  aes_pkg::word_idx_t count_q;
  aes_pkg::addr_t     addr_q;
  logic               accept;
  logic               last_push;

  assign accept = ctrl.req_start && !active_q;

  // One read in flight, so pushes and requests never overlap
  assign rd_req_o  = active_q && !pending_q && !fifo.full;
  assign rd_addr_o = addr_q;

  // Read data comes back one cycle after the request
  assign fifo.push      = pending_q;
  assign fifo.push_data = rd_data_i;

  assign last_push = pending_q &&
                     (count_q == aes_pkg::word_idx_t'(aes_pkg::LINE_LENGTH - 1));

  assign ctrl.ready_start = !active_q;
  assign ctrl.finished    = last_push;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      active_q  <= 1'b0;
      pending_q <= 1'b0;
      count_q   <= '0;
    end else if (clear_i) begin
      active_q  <= 1'b0;
      pending_q <= 1'b0;
      count_q   <= '0;
    end else begin
      pending_q <= rd_req_o;
      if (accept) begin
        active_q <= 1'b1;
        count_q  <= '0;
      end else if (pending_q) begin
        count_q <= count_q + 1'b1;
        if (last_push) active_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= ctrl.base_addr;
    end else if (rd_req_o) begin
      addr_q <= addr_q + aes_pkg::addr_t'(aes_pkg::WORD_BYTES);
    end
  end

  a_no_push_full: assert property (@(posedge clk) disable iff (!reset_n)
    fifo.push |-> !fifo.full)
    else $error("Push into a full FIFO");

endmodule

`default_nettype wire

// File: streamer_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface streamer_ctrl_if;

  logic           req_start;
  logic           ready_start;
  aes_pkg::addr_t base_addr;
  logic           finished;

  // Controller side
  modport ctrl (
    output req_start, base_addr,
    input  ready_start, finished
  );

  // Streamer side
  modport streamer (
    input  req_start, base_addr,
    output ready_start, finished
  );

endinterface

`default_nettype wire

// File: tb_aes_hwpe.sv
`timescale 1ns/1ps
`default_nettype none

module tb_aes_hwpe;

  localparam int RESET_CYCLES     = 16;
  localparam int LINE             = aes_pkg::LINE_LENGTH;
  localparam int WORD_CYCLE_BOUND = 64;
  localparam int JOB_TIMEOUT      = LINE * WORD_CYCLE_BOUND;
  localparam int NUM_TESTS        = 6;
  localparam int WATCHDOG_CYCLES  = RESET_CYCLES + NUM_TESTS * LINE * WORD_CYCLE_BOUND;
  localparam int MEM_WORDS        = 1024;

  logic           clk;
  logic           reset_n;
  logic           clear_i;
  logic           start_i;
  aes_pkg::addr_t pt_base_i;
  aes_pkg::addr_t ct_base_i;
  aes_pkg::key_t  key_i;
  logic           busy_o;
  logic           done_o;
  logic           rd_req_o;
  aes_pkg::addr_t rd_addr_o;
  aes_pkg::word_t rd_data_i;
  logic           wr_req_o;
  aes_pkg::addr_t wr_addr_o;
  aes_pkg::word_t wr_data_o;
  logic           wr_ready_i;

  aes_pkg::word_t mem [MEM_WORDS];
  aes_pkg::addr_t wr_addr_q [$];
  aes_pkg::word_t wr_data_q [$];
  int             done_count;
  logic           bp_en;
  logic [15:0]    lfsr_q;
  int             value_errors;
  int             other_errors;

  aes_hwpe_top i_dut (
    .clk        (clk),
    .reset_n    (reset_n),
    .clear_i    (clear_i),
    .start_i    (start_i),
    .pt_base_i  (pt_base_i),
    .ct_base_i  (ct_base_i),
    .key_i      (key_i),
    .busy_o     (busy_o),
    .done_o     (done_o),
    .rd_req_o   (rd_req_o),
    .rd_addr_o  (rd_addr_o),
    .rd_data_i  (rd_data_i),
    .wr_req_o   (wr_req_o),
    .wr_addr_o  (wr_addr_o),
    .wr_data_o  (wr_data_o),
    .wr_ready_i (wr_ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Memory content mixes every address bit
  function automatic aes_pkg::word_t fill_word(aes_pkg::addr_t addr);
    return (addr * 32'h9E3779B1) ^ {addr[15:0], ~addr[15:0]};
  endfunction

  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    if (s[0]) return (s >> 1) ^ 16'hB400;
    return s >> 1;
  endfunction

  // Key word 0 is the most significant slice
  function automatic aes_pkg::word_t key_word(aes_pkg::key_t key, int k);
    return key[127 - 32 * k -: 32];
  endfunction

  function automatic aes_pkg::word_t exp_data(aes_pkg::addr_t pt, aes_pkg::key_t key, int i);
    aes_pkg::addr_t a;
    a = pt + 32'(4 * i);
    return mem[a[11:2]] ^ key_word(key, i % 4);
  endfunction

  // Read port answers one cycle after the request
  always @(posedge clk) begin
    if (rd_req_o) rd_data_i <= mem[rd_addr_o[11:2]];
  end

  // Write ready is either held high or taken from the LFSR
  always @(posedge clk) begin
    if (bp_en) begin
      wr_ready_i <= lfsr_q[0];
      lfsr_q     <= lfsr_next(lfsr_q);
    end else begin
      wr_ready_i <= 1'b1;
    end
  end

  always @(posedge clk) begin
    if (reset_n && wr_req_o && wr_ready_i) begin
      wr_addr_q.push_back(wr_addr_o);
      wr_data_q.push_back(wr_data_o);
    end
    if (reset_n && done_o) done_count++;
  end

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    value_errors++;
    $display("FAILED %s: expected %h, actual %h", name, expected, actual);
  endtask

  task automatic report_problem(input string msg);
    other_errors++;
    $display("ERROR: %s", msg);
  endtask

  task automatic forget_writes();
    wr_addr_q.delete();
    wr_data_q.delete();
    done_count = 0;
  endtask

  task automatic pulse_start(input aes_pkg::addr_t pt, input aes_pkg::addr_t ct,
                             input aes_pkg::key_t key);
    @(posedge clk);
    pt_base_i <= pt;
    ct_base_i <= ct;
    key_i     <= key;
    start_i   <= 1'b1;
    @(posedge clk);
    start_i   <= 1'b0;
  endtask

  task automatic wait_idle(input string name);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (busy_o && cycles < JOB_TIMEOUT);
    if (busy_o) report_problem($sformatf("%s: busy_o still high after %0d cycles",
                                         name, JOB_TIMEOUT));
  endtask

  task automatic check_writes(input string name, input aes_pkg::addr_t pt,
                              input aes_pkg::addr_t ct, input aes_pkg::key_t key);
    int n;
    n = (wr_addr_q.size() < LINE) ? wr_addr_q.size() : LINE;
    if (wr_addr_q.size() != LINE)
      report_mismatch($sformatf("%s write count", name), 32'(LINE), 32'(wr_addr_q.size()));
    for (int i = 0; i < n; i++) begin
      if (wr_addr_q[i] != ct + 32'(4 * i))
        report_mismatch($sformatf("%s write %0d addr", name, i), ct + 32'(4 * i), wr_addr_q[i]);
      if (wr_data_q[i] != exp_data(pt, key, i))
        report_mismatch($sformatf("%s write %0d data", name, i), exp_data(pt, key, i),
                        wr_data_q[i]);
    end
    if (done_count != 1)
      report_mismatch($sformatf("%s done pulses", name), 32'd1, 32'(done_count));
  endtask

  task automatic run_job(input string name, input aes_pkg::addr_t pt, input aes_pkg::addr_t ct,
                         input aes_pkg::key_t key, input logic bp);
    forget_writes();
    bp_en <= bp;
    pulse_start(pt, ct, key);
    wait_idle(name);
    check_writes(name, pt, ct, key);
  endtask

  task automatic idle_after_reset();
    repeat (4) begin
      @(posedge clk);
      if (busy_o || done_o || rd_req_o || wr_req_o)
        report_problem("reset_idle: an output is high before any start");
    end
  endtask

  task automatic single_job();
    run_job("single_job", 32'h0000_0100, 32'h0000_0800,
            128'h0123_4567_89AB_CDEF_FEDC_BA98_7654_3210, 1'b0);
  endtask

  task automatic backpressure_job();
    run_job("backpressure", 32'h0000_0240, 32'h0000_0A00,
            128'hDEAD_BEEF_0BAD_F00D_CAFE_BABE_1234_5678, 1'b1);
  endtask

  task automatic back_to_back_jobs();
    forget_writes();
    bp_en <= 1'b0;
    pulse_start(32'h0000_0300, 32'h0000_0C00, 128'h1111_2222_3333_4444_5555_6666_7777_8888);
    // Inputs move on while the first job runs
    repeat (4) @(posedge clk);
    pt_base_i <= 32'h0000_0380;
    ct_base_i <= 32'h0000_0E00;
    key_i     <= 128'hA5A5_5A5A_0F0F_F0F0_3C3C_C3C3_9696_6969;
    wait_idle("back_to_back first");
    check_writes("back_to_back first", 32'h0000_0300, 32'h0000_0C00,
                 128'h1111_2222_3333_4444_5555_6666_7777_8888);
    run_job("back_to_back second", 32'h0000_0380, 32'h0000_0E00,
            128'hA5A5_5A5A_0F0F_F0F0_3C3C_C3C3_9696_6969, 1'b1);
  endtask

  task automatic start_while_busy();
    forget_writes();
    bp_en <= 1'b0;
    pulse_start(32'h0000_0400, 32'h0000_0900, 128'h0F1E_2D3C_4B5A_6978_8796_A5B4_C3D2_E1F0);
    repeat (6) @(posedge clk);
    if (!busy_o) report_problem("start_while_busy: job ended before the second start");
    start_i   <= 1'b1;
    pt_base_i <= 32'h0000_0500;
    @(posedge clk);
    start_i   <= 1'b0;
    wait_idle("start_while_busy");
    repeat (4) begin
      @(posedge clk);
      if (busy_o) report_problem("start_while_busy: a second job was started");
    end
    check_writes("start_while_busy", 32'h0000_0400, 32'h0000_0900,
                 128'h0F1E_2D3C_4B5A_6978_8796_A5B4_C3D2_E1F0);
  endtask

  task automatic clear_mid_job();
    int seen;
    int cycles;
    seen   = 0;
    cycles = 0;
    forget_writes();
    bp_en <= 1'b1;
    pulse_start(32'h0000_0600, 32'h0000_0B00, 128'h7766_5544_3322_1100_FFEE_DDCC_BBAA_9988);
    while (seen < 3 && cycles < JOB_TIMEOUT) begin
      @(posedge clk);
      cycles++;
      if (wr_req_o && wr_ready_i) seen++;
    end
    if (seen < 3) report_problem("clear_mid_job: three writes never appeared");
    clear_i <= 1'b1;
    @(posedge clk);
    clear_i <= 1'b0;
    // DUT must stay quiet and never signal done after the clear
    repeat (4) begin
      @(posedge clk);
      if (busy_o || rd_req_o || wr_req_o)
        report_problem("clear_mid_job: DUT still active after clear");
      if (done_o) report_problem("clear_mid_job: done_o pulsed after clear");
    end
    if (done_count != 0)
      report_mismatch("clear_mid_job done pulses", 32'd0, 32'(done_count));
    run_job("after_clear", 32'h0000_0680, 32'h0000_0D00,
            128'h2468_ACE0_1357_9BDF_0246_8ACE_1357_9BDF, 1'b0);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    reset_n      = 1'b0;
    clear_i      = 1'b0;
    start_i      = 1'b0;
    pt_base_i    = '0;
    ct_base_i    = '0;
    key_i        = '0;
    rd_data_i    = '0;
    wr_ready_i   = 1'b1;
    bp_en        = 1'b0;
    lfsr_q       = 16'd63656;
    done_count   = 0;
    value_errors = 0;
    other_errors = 0;
    for (int i = 0; i < MEM_WORDS; i++) mem[i] = fill_word(32'(4 * i));
    repeat (RESET_CYCLES) @(posedge clk);
    reset_n <= 1'b1;
    idle_after_reset();
    single_job();
    backpressure_job();
    back_to_back_jobs();
    start_while_busy();
    clear_mid_job();
    $display("Summary: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: word_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module word_fifo (
  input  wire logic    clk,
  input  wire logic    reset_n,
  input  wire logic    clear_i,
  word_fifo_if.buffer  fifo
);

  aes_pkg::word_t     mem_q [aes_pkg::FIFO_DEPTH];
  aes_pkg::fifo_ptr_t wr_ptr_q, rd_ptr_q;
  aes_pkg::fifo_cnt_t count_q;
  logic               do_push, do_pop;

  assign fifo.full  = (count_q == aes_pkg::fifo_cnt_t'(aes_pkg::FIFO_DEPTH));
  assign fifo.empty = (count_q == '0);

  // Guarded so a misbehaving neighbour cannot corrupt the count
  assign do_push = fifo.push && !fifo.full;
  assign do_pop  = fifo.pop && !fifo.empty;

  // Head of the queue
  assign fifo.pop_data = mem_q[rd_ptr_q];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      // Pointers wrap on their own since depth is a power of two
      unique case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= fifo.push_data;
    end
  end

  a_no_pop_empty: assert property (@(posedge clk) disable iff (!reset_n)
    fifo.pop |-> !fifo.empty)
    else $error("Pop from an empty FIFO");

endmodule

`default_nettype wire

// File: word_fifo_if.sv
`timescale 1ns/1ps
`default_nettype none

interface word_fifo_if;

  logic           push;
  aes_pkg::word_t push_data;
  logic           full;
  logic           pop;
  aes_pkg::word_t pop_data;
  logic           empty;

  modport producer (
    output push, push_data,
    input  full
  );

  modport buffer (
    input  push, push_data, pop,
    output full, pop_data, empty
  );

  modport consumer (
    output pop,
    input  pop_data, empty
  );

endinterface

`default_nettype wire
